// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= accStage1Tb
FLIST ?= accStage1.f
SRCS ?= $(shell grep -v '^+' $(FLIST))
VFLAGS ?= --binary --assert -j 0
OBJDIR ?= obj_dir
PASSMSG := === PASS ===

BIN := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) --top-module $(TOP) $(SRCS)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASSMSG)'

clean:
	rm -rf $(OBJDIR)

// ==== accStage1.f ====
hdl/accStagePkg.sv
hdl/instrDecode.sv
hdl/stageSequencer.sv
hdl/controlGen.sv
hdl/accStage1.sv
tests/accStage1Tb.sv

// ==== hdl/accStage1.sv ====
`default_nettype none

module accStage1 (
	input  logic                   clk,
	input  logic                   rst,
	input  accStagePkg::instr_t    instr,
	input  logic                   instrValid,
	input  logic [7:0]             mdrData,
	input  logic [7:0]             irData,
	output logic                   stageReady,
	output accStagePkg::ctrlWord_t ctrl,
	output logic [2:0]             numShift
);

	accStagePkg::decoded_t decoded;
	accStagePkg::stage_t state;
	accStagePkg::instr_t heldInstr;

	instrDecode decode (
		.instr   (instr),  // Live byte from stage 0
		.decoded (decoded)
	);

	stageSequencer sequencer (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instrValid (instrValid),
		.decoded    (decoded),
		.mdrData    (mdrData),
		.stageReady (stageReady),
		.state      (state),
		.heldInstr  (heldInstr)
	);

	controlGen control (
		.clk       (clk),
		.rst       (rst),
		.state     (state),
		.heldInstr (heldInstr),
		.mdrData   (mdrData),
		.irData    (irData),
		.ctrl      (ctrl),
		.numShift  (numShift)
	);

endmodule

`default_nettype wire

// ==== hdl/accStagePkg.sv ====
`default_nettype none

package accStagePkg;

	//////////////////////////////////////////////////
	// Instruction byte
	//////////////////////////////////////////////////

	typedef enum logic [4:0] {
		opAdd    = 5'b00000,
		opSub    = 5'b00001,
		opMulDiv = 5'b00010,
		opOr     = 5'b00011,
		opAnd    = 5'b00100,
		opShift  = 5'b00101,
		opLoad   = 5'b01010,
		opNop    = 5'b01111
	} opcode_t;

	typedef enum logic [2:0] {
		Dir = 3'b000,
		Ind = 3'b001,
		Imm = 3'b010
	} addrMode_t;

	typedef struct packed {
		logic dir;  // Must be 0 for a shift
		logic op;   // Multiply/divide, or left/right
		logic fill; // Shift fill bit, MULDIV indirect bit
	} shiftFlags_t;

	// Same three bits, read by addressing mode or by shift/muldiv fields
	typedef union packed {
		addrMode_t   mode;
		shiftFlags_t sh;
	} instrFlags_u;

	typedef struct packed {
		opcode_t     opcode;
		instrFlags_u flags;
	} instr_t;

	//////////////////////////////////////////////////
	// Sequencer states
	//////////////////////////////////////////////////

	typedef enum logic [5:0] {
		Idle,
		DirAddr, DirRead, DirLatch, OperandReady,
		IndAddr, IndRead, IndLatch, IndPtr, IndWait,
		ImmOperand,
		AddExec, SubExec, OrExec, AndExec,
		AddImm, SubImm, OrImm, AndImm,
		LoadExec, LoadImm,
		MdTest, MulEven, MulOddAdd, MulOddShift, MulOddDone,
		DivEven, DivOddSub, DivOddShift, DivOddDone,
		ShiftSelect, ShiftExec,
		NopExec
	} stage_t;

	//////////////////////////////////////////////////
	// Control word
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		Add = 2'd0,
		Sub = 2'd1,
		Or  = 2'd2,
		And = 2'd3
	} aluOp_t;

	typedef struct packed {
		logic       memRead;
		logic       addrFromMdr;    // Memory address from MDR
		logic       mdrLoad;
		aluOp_t     aluOp;
		logic       accLoad;
		logic       accFromOperand; // Bypass ALU into ACC
		logic       shiftEn;
		logic       shiftRight;
		logic       shiftFill;
		logic [1:0] spare;
	} ctrlWord_t;

	typedef struct packed {
		logic   legal;
		stage_t entry;
		logic   isMulDiv;
		logic   isShift;
	} decoded_t;

endpackage

`default_nettype wire

// ==== hdl/controlGen.sv ====
`default_nettype none

module controlGen (
	input  logic                   clk,
	input  logic                   rst,
	input  accStagePkg::stage_t    state,
	input  accStagePkg::instr_t    heldInstr,
	input  logic [7:0]             mdrData,
	input  logic [7:0]             irData,
	output accStagePkg::ctrlWord_t ctrl,
	output logic [2:0]             numShift
);

	accStagePkg::aluOp_t opAlu;
	logic [2:0] mdShift;

	always_comb begin
		case (heldInstr.opcode)
			accStagePkg::opSub: opAlu = accStagePkg::Sub;
			accStagePkg::opOr: opAlu = accStagePkg::Or;
			accStagePkg::opAnd: opAlu = accStagePkg::And;
			default: opAlu = accStagePkg::Add;
		endcase
	end

	//////////////////////////////////////////////////
	// Microcode
	//////////////////////////////////////////////////

	always_comb begin
		ctrl = '0;
		case (state)
			accStagePkg::DirRead, accStagePkg::IndRead: ctrl.memRead = 1'b1;
			accStagePkg::IndPtr: ctrl.addrFromMdr = 1'b1; // Pointer onto address bus
			accStagePkg::IndWait: begin
				ctrl.memRead = 1'b1;
				ctrl.addrFromMdr = 1'b1;
			end
			accStagePkg::DirLatch, accStagePkg::IndLatch: ctrl.mdrLoad = 1'b1;
			accStagePkg::AddExec, accStagePkg::SubExec,
			accStagePkg::OrExec, accStagePkg::AndExec,
			accStagePkg::AddImm, accStagePkg::SubImm,
			accStagePkg::OrImm, accStagePkg::AndImm: begin
				ctrl.accLoad = 1'b1;
				ctrl.aluOp = opAlu;
			end
			accStagePkg::LoadExec, accStagePkg::LoadImm: begin
				ctrl.accLoad = 1'b1;
				ctrl.accFromOperand = 1'b1;
			end
			accStagePkg::MulEven: begin
				ctrl.accLoad = 1'b1;
				ctrl.shiftEn = 1'b1;
			end
			accStagePkg::MulOddAdd: ctrl.aluOp = accStagePkg::Add;
			accStagePkg::MulOddShift: ctrl.shiftEn = 1'b1;
			accStagePkg::DivEven: begin
				ctrl.accLoad = 1'b1;
				ctrl.shiftEn = 1'b1;
				ctrl.shiftRight = 1'b1;
			end
			accStagePkg::DivOddSub: ctrl.aluOp = accStagePkg::Sub;
			accStagePkg::DivOddShift: begin
				ctrl.shiftEn = 1'b1;
				ctrl.shiftRight = 1'b1;
			end
			accStagePkg::MulOddDone, accStagePkg::DivOddDone: ctrl.accLoad = 1'b1;
			accStagePkg::ShiftExec: begin
				ctrl.shiftEn = 1'b1;
				ctrl.shiftRight = heldInstr.flags.sh.op;
				ctrl.shiftFill = heldInstr.flags.sh.fill;
			end
			default: ctrl = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Shift count
	//////////////////////////////////////////////////

	// Doubled for multiply, halved for divide
	assign mdShift = heldInstr.flags.sh.op ? {1'b0, mdrData[2:1]} : {mdrData[1:0], 1'b0};

	// Loaded in the state before each shiftEn state
	always_ff @(posedge clk) begin
		if (rst) begin
			numShift <= 3'd0;
		end else begin
			case (state)
				accStagePkg::ShiftSelect: begin
					if (heldInstr.opcode == accStagePkg::opShift) begin
						numShift <= irData[2:0];
					end
				end
				accStagePkg::MdTest: begin
					if (!mdrData[0]) begin
						numShift <= mdShift; // Even goes straight to shift
					end
				end
				accStagePkg::MulOddAdd, accStagePkg::DivOddSub: numShift <= mdShift;
				default: numShift <= numShift;
			endcase
		end
	end

	// Sequencer must only reach a shift through a count-loading state
	shiftAfterLoad: assert property (@(posedge clk) disable iff (rst)
		ctrl.shiftEn |-> $past(state) inside {accStagePkg::ShiftSelect,
			accStagePkg::MdTest, accStagePkg::MulOddAdd, accStagePkg::DivOddSub});

endmodule

`default_nettype wire

// ==== hdl/instrDecode.sv ====
`default_nettype none

module instrDecode (
	input  accStagePkg::instr_t   instr,
	output accStagePkg::decoded_t decoded
);

	accStagePkg::stage_t addrEntry;
	logic addrLegal;

	// Entry point for ops that take any of the three addressing modes
	always_comb begin
		addrLegal = 1'b1;
		case (instr.flags.mode)
			accStagePkg::Dir: begin
				addrEntry = accStagePkg::DirAddr;
			end
			accStagePkg::Ind: begin
				addrEntry = accStagePkg::IndAddr;
			end
			accStagePkg::Imm: begin
				addrEntry = accStagePkg::ImmOperand;
			end
			default: begin
				addrEntry = accStagePkg::Idle;
				addrLegal = 1'b0;
			end
		endcase
	end

	always_comb begin
		decoded.legal = 1'b0;
		decoded.entry = accStagePkg::Idle;
		decoded.isMulDiv = 1'b0;
		decoded.isShift = 1'b0;
		case (instr.opcode)
			accStagePkg::opAdd,
			accStagePkg::opSub,
			accStagePkg::opOr,
			accStagePkg::opAnd,
			accStagePkg::opLoad: begin
				decoded.legal = addrLegal;
				decoded.entry = addrEntry;
			end
			accStagePkg::opMulDiv: begin
				// Only 000 to 011, bit 0 selects indirect
				decoded.legal = !instr.flags.sh.dir;
				decoded.isMulDiv = 1'b1;
				if (instr.flags.sh.fill) begin
					decoded.entry = accStagePkg::IndAddr;
				end else begin
					decoded.entry = accStagePkg::DirAddr;
				end
			end
			accStagePkg::opShift: begin
				decoded.legal = !instr.flags.sh.dir;
				decoded.entry = accStagePkg::DirAddr; // Count fetched via IR
				decoded.isShift = 1'b1;
			end
			accStagePkg::opNop: begin
				decoded.legal = (instr.flags.mode == accStagePkg::Dir);
				decoded.entry = accStagePkg::NopExec;
			end
			default: begin
				decoded.legal = 1'b0; // Dropped opcode
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/stageSequencer.sv ====
`default_nettype none

module stageSequencer (
	input  logic                  clk,
	input  logic                  rst,
	input  accStagePkg::instr_t   instr,
	input  logic                  instrValid,
	input  accStagePkg::decoded_t decoded,
	input  logic [7:0]            mdrData,
	output logic                  stageReady,
	output accStagePkg::stage_t   state,
	output accStagePkg::instr_t   heldInstr
);

	accStagePkg::stage_t nextState;
	logic accept;
	logic heldShift;
	logic heldMulDiv;

	assign stageReady = (state == accStagePkg::Idle);
	assign accept = instrValid && stageReady && decoded.legal; // Illegal bytes are dropped

	//////////////////////////////////////////////////
	// State and latched instruction
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= accStagePkg::Idle;
			heldShift <= 1'b0;
			heldMulDiv <= 1'b0;
		end else begin
			state <= nextState;
			if (accept) begin
				heldShift <= decoded.isShift;
				heldMulDiv <= decoded.isMulDiv;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			heldInstr <= instr;
		end
	end

	//////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////

	always_comb begin
		nextState = accStagePkg::Idle;
		case (state)
			accStagePkg::Idle: begin
				if (accept) begin
					nextState = decoded.entry;
				end
			end
			accStagePkg::DirAddr: begin
				if (heldShift) begin
					nextState = accStagePkg::ShiftSelect;
				end else begin
					nextState = accStagePkg::DirRead;
				end
			end
			accStagePkg::DirRead: nextState = accStagePkg::DirLatch;
			accStagePkg::DirLatch: nextState = accStagePkg::OperandReady;
			accStagePkg::OperandReady: begin
				if (heldMulDiv) begin
					nextState = accStagePkg::ShiftSelect;
				end else begin
					case (heldInstr.opcode)
						accStagePkg::opAdd: nextState = accStagePkg::AddExec;
						accStagePkg::opSub: nextState = accStagePkg::SubExec;
						accStagePkg::opOr: nextState = accStagePkg::OrExec;
						accStagePkg::opAnd: nextState = accStagePkg::AndExec;
						accStagePkg::opLoad: nextState = accStagePkg::LoadExec;
						default: nextState = accStagePkg::Idle;
					endcase
				end
			end
			accStagePkg::IndAddr: nextState = accStagePkg::IndRead;
			accStagePkg::IndRead: nextState = accStagePkg::IndLatch;
			accStagePkg::IndLatch: nextState = accStagePkg::IndPtr;
			accStagePkg::IndPtr: nextState = accStagePkg::IndWait;
			accStagePkg::IndWait: nextState = accStagePkg::DirLatch; // Operand read done here
			accStagePkg::ImmOperand: begin
				case (heldInstr.opcode)
					accStagePkg::opAdd: nextState = accStagePkg::AddImm;
					accStagePkg::opSub: nextState = accStagePkg::SubImm;
					accStagePkg::opOr: nextState = accStagePkg::OrImm;
					accStagePkg::opAnd: nextState = accStagePkg::AndImm;
					accStagePkg::opLoad: nextState = accStagePkg::LoadImm;
					default: nextState = accStagePkg::Idle;
				endcase
			end
			accStagePkg::ShiftSelect: begin
				if (heldShift) begin
					nextState = accStagePkg::ShiftExec;
				end else begin
					nextState = accStagePkg::MdTest;
				end
			end
			accStagePkg::MdTest: begin
				// Divide bit, then operand parity
				case ({heldInstr.flags.sh.op, mdrData[0]})
					2'b00: nextState = accStagePkg::MulEven;
					2'b01: nextState = accStagePkg::MulOddAdd;
					2'b10: nextState = accStagePkg::DivEven;
					default: nextState = accStagePkg::DivOddSub;
				endcase
			end
			accStagePkg::MulOddAdd: nextState = accStagePkg::MulOddShift;
			accStagePkg::MulOddShift: nextState = accStagePkg::MulOddDone;
			accStagePkg::DivOddSub: nextState = accStagePkg::DivOddShift;
			accStagePkg::DivOddShift: nextState = accStagePkg::DivOddDone;
			default: nextState = accStagePkg::Idle; // Exec states finish
		endcase
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Handshake with stage 0 across cycles
	acceptLeavesIdle: assert property (@(posedge clk) disable iff (rst)
		accept |=> !stageReady);

endmodule

`default_nettype wire

// ==== tests/accStage1Tb.sv ====
`default_nettype none

module accStage1Tb;

	localparam int MaxTests = 32;

	logic clk;
	logic rst;
	accStagePkg::instr_t instr;
	logic instrValid;
	logic [7:0] mdrData;
	logic [7:0] irData;
	logic stageReady;
	accStagePkg::ctrlWord_t ctrl;
	logic [2:0] numShift;

	reg [8*16-1:0] testName [0:MaxTests-1];
	logic [7:0] testInstr [0:MaxTests-1];
	logic [7:0] testMdr [0:MaxTests-1];
	logic [7:0] testIr [0:MaxTests-1];
	int testBusy [0:MaxTests-1];
	int testAccLoads [0:MaxTests-1];
	logic [7:0] testShift [0:MaxTests-1]; // ff when no shift cycle
	int numTests;

	int valueErrors;
	int otherErrors;
	int acceptCount;
	int legalCount;
	int cycleCount;
	int cycleLimit;
	bit limitSet;
	bit timedOut;
	bit presented; // Next instruction already on the bus
	bit prevReady;

	accStage1 DUT (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instrValid (instrValid),
		.mdrData    (mdrData),
		.irData     (irData),
		.stageReady (stageReady),
		.ctrl       (ctrl),
		.numShift   (numShift)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic reportMismatch(input reg [8*16-1:0] name, input string what,
			input int expected, input int actual);
		valueErrors++;
		$display("error %0s %0s: expected %0h, actual %0h", name, what, expected, actual);
	endtask

	task automatic readTests();
		int fd;
		int got;
		reg [8*96-1:0] lineBuf;
		reg [8*16-1:0] nameTmp;
		logic [7:0] instrTmp;
		logic [7:0] mdrTmp;
		logic [7:0] irTmp;
		logic [7:0] shiftTmp;
		int busyTmp;
		int accTmp;
		numTests = 0;
		fd = $fopen("tests/accStage1_testdata.txt", "r");
		if (fd == 0) begin
			otherErrors++;
			$display("could not open the test data file");
		end else begin
			while (!$feof(fd)) begin
				lineBuf = '0;
				got = $fgets(lineBuf, fd);
				got = $sscanf(lineBuf, "%s %h %h %h %d %d %h", nameTmp, instrTmp, mdrTmp,
					irTmp, busyTmp, accTmp, shiftTmp);
				if (got == 7 && numTests < MaxTests) begin // Comment lines fail the scan
					testName[numTests] = nameTmp;
					testInstr[numTests] = instrTmp;
					testMdr[numTests] = mdrTmp;
					testIr[numTests] = irTmp;
					testBusy[numTests] = busyTmp;
					testAccLoads[numTests] = accTmp;
					testShift[numTests] = shiftTmp;
					numTests++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic checkAccWord(input int t);
		logic [4:0] op;
		int expAlu;
		op = testInstr[t][7:3];
		case (op)
			accStagePkg::opAdd: expAlu = 0;
			accStagePkg::opSub: expAlu = 1;
			accStagePkg::opOr: expAlu = 2;
			accStagePkg::opAnd: expAlu = 3;
			default: expAlu = -1;
		endcase
		if (expAlu >= 0 && int'(ctrl.aluOp) != expAlu) begin
			reportMismatch(testName[t], "aluOp", expAlu, int'(ctrl.aluOp));
		end
		if (ctrl.accFromOperand != (op == accStagePkg::opLoad)) begin
			reportMismatch(testName[t], "accFromOperand", int'(op == accStagePkg::opLoad),
				int'(ctrl.accFromOperand));
		end
	endtask

	task automatic checkShiftWord(input int t);
		logic [4:0] op;
		op = testInstr[t][7:3];
		if (testShift[t] == 8'hff) begin
			otherErrors++;
			$display("%0s: shift enable seen where no shift was expected", testName[t]);
		end else if (numShift != testShift[t][2:0]) begin
			reportMismatch(testName[t], "numShift", int'(testShift[t][2:0]), int'(numShift));
		end
		if (ctrl.shiftRight != testInstr[t][1]) begin
			reportMismatch(testName[t], "shiftRight", int'(testInstr[t][1]), int'(ctrl.shiftRight));
		end
		if (op == accStagePkg::opShift && ctrl.shiftFill != testInstr[t][0]) begin
			reportMismatch(testName[t], "shiftFill", int'(testInstr[t][0]), int'(ctrl.shiftFill));
		end
	endtask

	// Leaves the caller at a falling edge with the instruction on the bus
	task automatic presentTest(input int t);
		int gap;
		gap = int'($urandom % 6);
		repeat (gap) @(posedge clk);
		@(posedge clk);
		instr <= testInstr[t];
		instrValid <= 1'b1;
		@(negedge clk);
	endtask

	task automatic runLegal(input int t);
		int busy;
		int accLoads;
		int shifts;
		busy = 0;
		accLoads = 0;
		shifts = 0;
		while (!stageReady) begin
			@(negedge clk);
		end
		@(posedge clk); // Acceptance edge
		mdrData <= testMdr[t];
		irData <= testIr[t];
		if (t + 1 < numTests && $urandom % 2 == 0) begin
			instr <= testInstr[t + 1]; // Held under back-pressure
			presented = 1'b1;
		end else begin
			instrValid <= 1'b0;
			presented = 1'b0;
		end
		@(negedge clk);
		while (!stageReady) begin
			busy++;
			if (ctrl.accLoad) begin
				accLoads++;
				if (accLoads == 1) begin
					checkAccWord(t);
				end
			end
			if (ctrl.shiftEn) begin
				shifts++;
				checkShiftWord(t);
			end
			@(negedge clk);
		end
		if (busy != testBusy[t]) begin
			reportMismatch(testName[t], "busy cycles", testBusy[t], busy);
		end
		if (accLoads != testAccLoads[t]) begin
			reportMismatch(testName[t], "accLoad cycles", testAccLoads[t], accLoads);
		end
		if (testShift[t] != 8'hff && shifts == 0) begin
			otherErrors++;
			$display("%0s: no shift cycle was seen", testName[t]);
		end
	endtask

	task automatic runIllegal(input int t);
		repeat (4) begin
			@(negedge clk);
			if (!stageReady) begin
				otherErrors++;
				$display("%0s: refused instruction was accepted", testName[t]);
			end
		end
		@(posedge clk);
		instrValid <= 1'b0;
		presented = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Idle monitor and timeout
	//////////////////////////////////////////////////

	initial begin
		prevReady = 1'b1;
		acceptCount = 0;
		forever begin
			@(negedge clk);
			if (!rst) begin
				if (stageReady && ctrl != '0) begin
					otherErrors++;
					$display("control word active while the stage is idle");
				end
				if (prevReady && !stageReady) begin
					acceptCount++;
				end
				prevReady = stageReady;
			end
		end
	end

	initial begin
		cycleCount = 0;
		timedOut = 1'b0;
		while (!timedOut) begin
			@(posedge clk);
			cycleCount++;
			if (limitSet && cycleCount > cycleLimit) begin
				timedOut = 1'b1;
			end
		end
		$display("run stopped after %0d cycles without finishing the tests", cycleCount);
		$display("=== FAIL ===");
		$finish;
	end

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		rst = 1'b1;
		instr = '0;
		instrValid = 1'b0;
		mdrData = 8'h00;
		irData = 8'h00;
		valueErrors = 0;
		otherErrors = 0;
		legalCount = 0;
		limitSet = 1'b0;
		presented = 1'b0;
		void'($urandom(32'hd287));
		readTests();
		cycleLimit = 100;
		for (int t = 0; t < numTests; t++) begin
			cycleLimit += testBusy[t] + 40;
		end
		limitSet = 1'b1;
		if (numTests == 0) begin
			otherErrors++;
			$display("no tests were read from the data file");
		end
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if (!stageReady || ctrl != '0 || numShift != 3'd0) begin
			otherErrors++;
			$display("outputs are not at their reset values");
		end
		for (int t = 0; t < numTests; t++) begin
			if (!presented) begin
				presentTest(t);
			end
			if (testBusy[t] > 0) begin
				legalCount++;
				runLegal(t);
			end else begin
				runIllegal(t);
			end
		end
		repeat (4) @(negedge clk);
		if (acceptCount != legalCount) begin
			reportMismatch("acceptances", "count", legalCount, acceptCount);
		end
		$display("errors: %0d value, %0d other", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/accStage1_testdata.txt ====
# test instr mdrData irData busyCycles accLoadCycles numShift
# bytes and numShift in hex, numShift ff when the test has no shift cycle
addDir 00 3c 00 5 1 ff
addInd 01 3c 00 8 1 ff
addImm 02 3c 00 2 1 ff
subDir 08 11 00 5 1 ff
subImm 0a 11 00 2 1 ff
orDir 18 5a 00 5 1 ff
orInd 19 5a 00 8 1 ff
orImm 1a 5a 00 2 1 ff
andDir 20 0f 00 5 1 ff
andImm 22 0f 00 2 1 ff
loadDir 50 77 00 5 1 ff
loadInd 51 77 00 8 1 ff
loadImm 52 77 00 2 1 ff
dropOp 30 00 00 0 0 ff
shlZero 28 00 05 3 0 05
shrOne 2b 00 0f 3 0 07
shlOne 29 00 03 3 0 03
badMode 03 00 00 0 0 ff
mulEven 10 56 00 7 1 04
mulOdd 10 a7 00 9 1 06
mulIndOdd 11 33 00 12 1 06
divEven 12 2c 00 7 1 02
divIndEven 13 4a 00 10 1 01
divOdd 12 6f 00 9 1 03
badShift 2c 00 00 0 0 ff
nopExec 78 00 00 1 0 ff
badMulDiv 14 00 00 0 0 ff
